// File: compile.f
+incdir+source
source/aesPkg.sv
source/aesStepIf.sv
source/aesControl.sv
source/aesKeySchedule.sv
source/aesInvRound.sv
source/aesDecrypt.sv
test/tbClock.sv
test/aesChecker.sv
test/aesDecrypt_props.sv
test/aesDecrypt_tb.sv

// File: source/aesControl.sv
// AES decryption controller
// sequences key expansion and the inverse rounds one step per cycle,
// then holds done until start is released
`timescale 1ns/1ps
`include "aes_params.svh"

module aesControl (
	input  logic   Clk,
	input  logic   reset,
	input  logic   start,
	output logic   done,
	aesStepIf.ctrl step
);
	import aesPkg::*;

	typedef enum logic [2:0] {
		Wait,
		KeyExpansion,
		Ark,
		Isr,
		Isb,
		Imc,
		Done
	} ctrlStateT;

	ctrlStateT state, nextState;
	roundIdxT  keyCnt;   // source key of the next expansion
	roundIdxT  roundCnt; // key used by the next Ark

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= Wait;
			keyCnt <= '0;
			roundCnt <= '0;
		end
		else
		begin
			state <= nextState;
			if (step.load)
			begin
				keyCnt <= '0;
				roundCnt <= roundIdxT'(`AES_ROUNDS);
			end
			else
			begin
				if (step.expand)
					keyCnt <= keyCnt + 4'd1;
				if (state == Ark && roundCnt != '0) // stop at key 0
					roundCnt <= roundCnt - 4'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		unique case (state)
			Wait:
				if (start)
					nextState = KeyExpansion;
			KeyExpansion:
				if (keyCnt == roundIdxT'(`AES_ROUNDS - 1))
					nextState = Ark;
			Ark:
				if (roundCnt == roundIdxT'(`AES_ROUNDS))
					nextState = Isr; // first round has no InvMixColumns
				else if (roundCnt == '0)
					nextState = Done;
				else
					nextState = Imc;
			Isr:  nextState = Isb;
			Isb:  nextState = Ark;
			Imc:  nextState = Isr;
			Done:
				if (!start)
					nextState = Wait;
			default: nextState = Wait;
		endcase
	end

	// step decode
	always_comb
	begin
		step.stepOp = stepArk;
		unique case (state)
			Isr:     step.stepOp = stepIsr;
			Isb:     step.stepOp = stepIsb;
			Imc:     step.stepOp = stepImc;
			default: step.stepOp = stepArk;
		endcase
	end

	assign step.load   = (state == Wait) && start;
	assign step.expand = (state == KeyExpansion);
	assign step.stepEn = (state == Ark) || (state == Isr) || (state == Isb) || (state == Imc);
	assign step.keyIdx = (state == KeyExpansion) ? keyCnt : roundCnt;
	assign done        = (state == Done);

endmodule

// File: source/aesDecrypt.sv
// AES-128 decryption core top level
// connects the controller, key schedule and round datapath
// level start in, done held with the plaintext until start falls
`timescale 1ns/1ps
`include "aes_params.svh"

module aesDecrypt (
	input  logic                       Clk,
	input  logic                       reset,
	input  logic                       start,
	input  logic [`AES_BLOCK_BITS-1:0] key,
	input  logic [`AES_BLOCK_BITS-1:0] cipherText,
	output logic [`AES_BLOCK_BITS-1:0] plainText,
	output logic                       done
);
	import aesPkg::*;

	aesBlockT roundKey; // selected by step.keyIdx

	aesStepIf step ();

	aesControl control (
		.Clk   (Clk),
		.reset (reset),
		.start (start),
		.done  (done),
		.step  (step.ctrl)
	);

	aesKeySchedule keySchedule (
		.Clk      (Clk),
		.keyIn    (key),
		.step     (step.exec),
		.roundKey (roundKey)
	);

	aesInvRound invRound (
		.Clk      (Clk),
		.cipherIn (cipherText),
		.roundKey (roundKey),
		.step     (step.exec),
		.state    (plainText)
	);

endmodule

// File: source/aesInvRound.sv
// AES inverse round datapath
// holds the 128-bit state and applies one inverse cipher step per cycle:
// AddRoundKey, InvShiftRows, InvSubBytes or InvMixColumns
`timescale 1ns/1ps

module aesInvRound (
	input  logic             Clk,
	input  aesPkg::aesBlockT cipherIn,
	input  aesPkg::aesBlockT roundKey,
	aesStepIf.exec           step,
	output aesPkg::aesBlockT state
);
	import aesPkg::*;

	aesBlockT nextState;

	// byte r + 4c is row r of column c
	function automatic aesBlockT invShiftRows(input aesBlockT s);
		aesBlockT res;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				res[127 - 8*(r + 4*c) -: 8] = s[127 - 8*(r + 4*((c - r + 4) % 4)) -: 8];
		return res;
	endfunction

	function automatic aesBlockT invSubBytes(input aesBlockT s);
		aesBlockT res;
		for (int i = 0; i < 16; i++)
			res[127 - 8*i -: 8] = invSbox(s[127 - 8*i -: 8]);
		return res;
	endfunction

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// GF(2^8) product with a 4-bit constant
	function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [3:0] m);
		logic [7:0] x2, x4, x8;
		x2 = xtime(a);
		x4 = xtime(x2);
		x8 = xtime(x4);
		return (m[3] ? x8 : 8'h00) ^ (m[2] ? x4 : 8'h00) ^ (m[1] ? x2 : 8'h00) ^ (m[0] ? a : 8'h00);
	endfunction

	function automatic aesBlockT invMixColumns(input aesBlockT s);
		aesBlockT res;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				res[127 - 8*(r + 4*c) -: 8] =
					gfMul(s[127 - 8*(r + 4*c) -: 8], 4'he) ^
					gfMul(s[127 - 8*((r + 1) % 4 + 4*c) -: 8], 4'hb) ^
					gfMul(s[127 - 8*((r + 2) % 4 + 4*c) -: 8], 4'hd) ^
					gfMul(s[127 - 8*((r + 3) % 4 + 4*c) -: 8], 4'h9);
		return res;
	endfunction

	always_comb
	begin
		unique case (step.stepOp)
			stepArk: nextState = state ^ roundKey;
			stepIsr: nextState = invShiftRows(state);
			stepIsb: nextState = invSubBytes(state);
			stepImc: nextState = invMixColumns(state);
			default: nextState = state;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (step.load)
			state <= cipherIn;
		else if (step.stepEn)
			state <= nextState; // plaintext after the last Ark
	end

endmodule

// File: source/aesKeySchedule.sv
// AES-128 key schedule
// expands the cipher key into eleven round keys, one per expand cycle,
// and serves the key selected by the controller
`timescale 1ns/1ps
`include "aes_params.svh"

module aesKeySchedule (
	input  logic             Clk,
	input  aesPkg::aesBlockT keyIn,
	aesStepIf.exec           step,
	output aesPkg::aesBlockT roundKey
);
	import aesPkg::*;

	aesBlockT    keyMem [0:`AES_ROUNDS];
	aesBlockT    nextKey;
	logic [31:0] w0, w1, w2, w3;
	logic [31:0] rotSub;
	logic [7:0]  rcon;

	assign roundKey = keyMem[step.keyIdx];

	// source key during expansion is the current keyIdx
	assign {w0, w1, w2, w3} = roundKey;

	always_comb
	begin
		unique case (step.keyIdx)
			4'd0:    rcon = 8'h01;
			4'd1:    rcon = 8'h02;
			4'd2:    rcon = 8'h04;
			4'd3:    rcon = 8'h08;
			4'd4:    rcon = 8'h10;
			4'd5:    rcon = 8'h20;
			4'd6:    rcon = 8'h40;
			4'd7:    rcon = 8'h80;
			4'd8:    rcon = 8'h1b;
			4'd9:    rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	end

	// RotWord then SubWord on the last word
	assign rotSub = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};

	always_comb
	begin
		nextKey[127:96] = w0 ^ rotSub ^ {rcon, 24'h0};
		nextKey[95:64]  = w1 ^ nextKey[127:96];
		nextKey[63:32]  = w2 ^ nextKey[95:64];
		nextKey[31:0]   = w3 ^ nextKey[63:32];
	end

	always_ff @(posedge Clk)
	begin
		if (step.load)
			keyMem[0] <= keyIn;
		else if (step.expand)
			keyMem[step.keyIdx + 4'd1] <= nextKey; // next slot
	end

endmodule

// File: source/aesPkg.sv
// AES shared types and byte substitution
// block, step and round index types plus the forward and inverse S-box
// lookups used by the key schedule and the round datapath
`include "aes_params.svh"

package aesPkg;

	typedef logic [`AES_BLOCK_BITS-1:0] aesBlockT; // byte 0 in the top bits

	typedef enum logic [1:0] {
		stepArk,
		stepIsr,
		stepIsb,
		stepImc
	} stepOpT;

	typedef logic [3:0] roundIdxT; // 0 to 10

	//////////////////////////////////////////////////
	// S-box tables, entry 0 in the top byte
	//////////////////////////////////////////////////

	localparam logic [2047:0] sboxTable = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [2047:0] invSboxTable = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// forward substitution, key schedule only
	function automatic logic [7:0] sbox(input logic [7:0] b);
		return sboxTable[2047 - 8*b -: 8];
	endfunction

	// inverse substitution for the datapath
	function automatic logic [7:0] invSbox(input logic [7:0] b);
		return invSboxTable[2047 - 8*b -: 8];
	endfunction

endpackage

// File: source/aesStepIf.sv
// AES step command bus
// carries load, key expansion and datapath step commands from the
// controller to the round datapath and the key schedule
`timescale 1ns/1ps

interface aesStepIf;
	import aesPkg::*;

	logic     load;   // capture key and ciphertext
	logic     expand; // next round key
	logic     stepEn;
	stepOpT   stepOp;
	roundIdxT keyIdx;

	modport ctrl (output load, expand, stepEn, stepOp, keyIdx);
	modport exec (input load, expand, stepEn, stepOp, keyIdx);

endinterface

// File: source/aes_params.svh
// AES-128 decryption core parameters
// round count, block width and the fixed start-to-done latency
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

`define AES_ROUNDS        10
`define AES_BLOCK_BITS    128

// sampling edge of start to the edge that enters Done
`define AES_START_TO_DONE 50

`endif

// File: test/aesChecker.sv
// AES-128 result checker
// reference key expansion and inverse cipher written from FIPS-197,
// compared with the core at every rising done, plus handshake checks
`timescale 1ns/1ps

module aesChecker (
	input logic         Clk,
	input logic         reset,
	input logic         start,
	input logic         done,
	input logic [127:0] key,
	input logic [127:0] cipherText,
	input logic [127:0] plainText
);
	import aesPkg::*;

	logic [7:0]   fwdTable [256]; // forward S-box, rebuilt from the inverse one
	logic [127:0] expected [$];
	logic [127:0] heldText;
	logic [127:0] want;
	logic         startPos, resetPos, doneLast;
	int           checkCount, valueErrors, protocolErrors;

	// shift-and-add product in GF(2^8)
	function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		p = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p ^= a;
			a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// 44 words, word 0 in the top bits
	function automatic logic [1407:0] expandKey(input logic [127:0] k);
		logic [1407:0] w;
		logic [31:0]   t;
		logic [7:0]    rc;
		w = '0;
		w[1407 -: 128] = k;
		rc = 8'h01;
		for (int i = 4; i < 44; i++)
		begin
			t = w[1407 - 32*(i - 1) -: 32];
			if (i % 4 == 0)
			begin
				t = {fwdTable[t[23:16]] ^ rc, fwdTable[t[15:8]], fwdTable[t[7:0]],
					fwdTable[t[31:24]]};
				rc = gmul(rc, 8'h02);
			end
			w[1407 - 32*i -: 32] = w[1407 - 32*(i - 4) -: 32] ^ t;
		end
		return w;
	endfunction

	function automatic logic [127:0] decryptModel(input logic [127:0] k,
		input logic [127:0] ct);
		logic [1407:0] w;
		logic [127:0]  rk;
		logic [127:0]  res;
		logic [7:0]    s [16];
		logic [7:0]    t [16];
		logic [7:0]    coef [4];
		coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
		w = expandKey(k);
		for (int i = 0; i < 16; i++)
			s[i] = ct[127 - 8*i -: 8];
		for (int rnd = 10; rnd >= 0; rnd--)
		begin
			if (rnd < 10)
			begin
				for (int i = 0; i < 16; i++)
					t[i % 4 + 4*((i / 4 + i % 4) % 4)] = s[i]; // row r moves right by r
				for (int i = 0; i < 16; i++)
					s[i] = invSbox(t[i]);
			end
			rk = w[1407 - 128*rnd -: 128];
			for (int i = 0; i < 16; i++)
				s[i] ^= rk[127 - 8*i -: 8];
			if (rnd > 0 && rnd < 10)
			begin
				for (int i = 0; i < 16; i++)
				begin
					t[i] = 8'h00;
					for (int j = 0; j < 4; j++)
						t[i] ^= gmul(coef[j], s[(i % 4 + j) % 4 + 4*(i / 4)]);
				end
				for (int i = 0; i < 16; i++)
					s[i] = t[i];
			end
		end
		for (int i = 0; i < 16; i++)
			res[127 - 8*i -: 8] = s[i];
		return res;
	endfunction

	initial
	begin
		for (int i = 0; i < 256; i++)
			fwdTable[invSbox(8'(i))] = 8'(i);
		checkCount = 0;
		valueErrors = 0;
		protocolErrors = 0;
		doneLast = 1'b0;
		startPos = 1'b0;
		resetPos = 1'b1;
		// known answer, FIPS-197 appendix C.1
		if (decryptModel(128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a) !== 128'h00112233445566778899aabbccddeeff)
		begin
			$display("[FAIL] %0t: reference model misses the FIPS-197 vector", $time);
			valueErrors++;
		end
	end

	//////////////////////////////////////////////////
	// inputs at the rising edge, outputs at the falling edge
	//////////////////////////////////////////////////

	always @(posedge Clk)
	begin
		if (!reset && start && !startPos) // start rises only in Wait
			expected.push_back(decryptModel(key, cipherText));
		startPos <= start;
		resetPos <= reset;
	end

	always @(negedge Clk)
	begin
		if (resetPos && done === 1'b1)
		begin
			$display("done is high after a reset edge at %0t", $time);
			protocolErrors++;
		end
		if (!resetPos)
		begin
			if (done === 1'b1 && !doneLast)
			begin
				if (expected.size() == 0)
				begin
					$display("done rose at %0t with no block started", $time);
					protocolErrors++;
				end
				else
				begin
					want = expected.pop_front();
					checkCount++;
					heldText = plainText;
					if (plainText !== want)
					begin
						$display("[FAIL] %0t: plainText %h, expected %h", $time, plainText, want);
						valueErrors++;
					end
				end
			end
			else if (done === 1'b1 && plainText !== heldText)
			begin
				$display("[FAIL] %0t: plainText changed to %h while done held", $time, plainText);
				valueErrors++;
			end
			if (doneLast && !startPos && done !== 1'b0)
			begin
				$display("done stayed high after start was released, at %0t", $time);
				protocolErrors++;
			end
			if (doneLast && startPos && done !== 1'b1)
			begin
				$display("done fell while start was still high, at %0t", $time);
				protocolErrors++;
			end
		end
		doneLast = (done === 1'b1);
	end

endmodule

// File: test/aesDecrypt_props.sv
// handshake and latency assertions for the AES decryption core
// attached to every aesDecrypt instance by bind
`timescale 1ns/1ps
`include "aes_params.svh"

module aesDecrypt_props (
	input logic         Clk,
	input logic         reset,
	input logic         start,
	input logic         done,
	input logic [127:0] plainText
);

	// load edge to the edge that enters Done
	latency: assert property (@(posedge Clk) disable iff (reset)
		$rose(start) |-> ##(`AES_START_TO_DONE + 1) $rose(done))
		else $error("done did not rise %0d cycles after start", `AES_START_TO_DONE);

	noStrayDone: assert property (@(posedge Clk) disable iff (reset)
		!start |=> !$rose(done))
		else $error("done rose without start");

	holdWhileStart: assert property (@(posedge Clk) disable iff (reset)
		done && start |=> done && $stable(plainText))
		else $error("done or plainText changed while start was high");

	releaseDone: assert property (@(posedge Clk) disable iff (reset)
		done && !start |=> !done)
		else $error("done did not fall one cycle after start fell");

	resetClears: assert property (@(posedge Clk) reset |=> !done)
		else $error("done high after a reset edge");

endmodule

bind aesDecrypt aesDecrypt_props props (
	.Clk       (Clk),
	.reset     (reset),
	.start     (start),
	.done      (done),
	.plainText (plainText)
);

// File: test/aesDecrypt_tb.sv
// AES-128 decryption testbench top
// runs the FIPS-197 vector and random blocks through the core,
// bounds the run with a cycle limit and prints the error counts
`timescale 1ns/1ps
`include "aes_params.svh"

module aesDecrypt_tb;

	localparam int blockCount = 21;
	localparam int cycleLimit = 25 * (`AES_START_TO_DONE + 20);

	logic         Clk, reset;
	logic         start, done;
	logic [127:0] key, cipherText, plainText;
	logic [31:0]  lfsr;
	int           cycles;
	int           tbErrors;

	tbClock clockGen (.Clk(Clk), .reset(reset));

	aesDecrypt uut (
		.Clk        (Clk),
		.reset      (reset),
		.start      (start),
		.key        (key),
		.cipherText (cipherText),
		.plainText  (plainText),
		.done       (done)
	);

	aesChecker resultCheck (
		.Clk        (Clk),
		.reset      (reset),
		.start      (start),
		.done       (done),
		.key        (key),
		.cipherText (cipherText),
		.plainText  (plainText)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit
	task automatic drawBits(input int n, output logic [127:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// one block from start to release
	//////////////////////////////////////////////////

	task automatic runBlock(input logic [127:0] k, input logic [127:0] ct);
		logic [127:0] hold, gap, junk;
		@(negedge Clk);
		key = k;
		cipherText = ct;
		start = 1'b1;
		do
			@(negedge Clk);
		while (done !== 1'b1);
		drawBits(2, hold);
		repeat (hold[1:0])
		begin
			drawBits(128, junk);
			cipherText = junk; // ignored after the load edge
			key = ~junk;
			@(negedge Clk);
		end
		start = 1'b0;
		drawBits(2, gap);
		repeat (gap[1:0]) @(negedge Clk); // zero gives back-to-back blocks
	endtask

	task automatic reportAndFinish();
		int total;
		if (resultCheck.checkCount != blockCount)
		begin
			$display("expected %0d results, saw %0d", blockCount, resultCheck.checkCount);
			tbErrors++;
		end
		total = tbErrors + resultCheck.valueErrors + resultCheck.protocolErrors;
		$display("results %0d, value errors %0d, handshake errors %0d, other errors %0d",
			resultCheck.checkCount, resultCheck.valueErrors, resultCheck.protocolErrors, tbErrors);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	initial
	begin
		logic [127:0] k, ct;
		start = 1'b0;
		key = '0;
		cipherText = '0;
		lfsr = 32'd93479;
		cycles = 0;
		tbErrors = 0;
		@(negedge Clk);
		while (reset !== 1'b0)
			@(negedge Clk);
		runBlock(128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		for (int i = 1; i < blockCount; i++)
		begin
			drawBits(128, k);
			drawBits(128, ct);
			runBlock(k, ct);
		end
		repeat (4) @(negedge Clk);
		reportAndFinish();
	end

	always @(posedge Clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout after %0d cycles, the core stopped answering", cycles);
			tbErrors++;
			reportAndFinish();
		end
	end

endmodule

// File: test/tbClock.sv
// testbench clock and reset
// 8 ns clock, reset held for the first 16 rising edges
`timescale 1ns/1ps

module tbClock (
	output logic Clk,
	output logic reset
);

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge Clk);
		@(negedge Clk);
		reset = 1'b0; // released on a falling edge
	end

endmodule
